// ==== hw/rv_decoder_pkg.sv ====
// Fixed RV32I encodings only, and no branch, jump, CSR or MRET support in these types
`default_nettype none

package rv_decoder_pkg;

  //////////////////////////////
  // Widths and basic types
  //////////////////////////////
  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////
  typedef enum logic [6:0] {
    OPCODE_LOAD    = 7'b0000011,
    OPCODE_MISCMEM = 7'b0001111,
    OPCODE_OPIMM   = 7'b0010011,
    OPCODE_AUIPC   = 7'b0010111,
    OPCODE_STORE   = 7'b0100011,
    OPCODE_OP      = 7'b0110011,
    OPCODE_LUI     = 7'b0110111,
    OPCODE_SYSTEM  = 7'b1110011
  } opcode_e;

  // Instruction bit 30 followed by funct3
  typedef enum logic [3:0] {
    ALU_OP_ADD  = 4'b0000,
    ALU_OP_SLL  = 4'b0001,
    ALU_OP_SLT  = 4'b0010,
    ALU_OP_SLTU = 4'b0011,
    ALU_OP_XOR  = 4'b0100,
    ALU_OP_SRL  = 4'b0101,
    ALU_OP_OR   = 4'b0110,
    ALU_OP_AND  = 4'b0111,
    ALU_OP_SUB  = 4'b1000,
    ALU_OP_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_I_SHIFT, IMM_S, IMM_U} imm_fmt_e;

  typedef enum logic [2:0] {
    KIND_ALU, KIND_LOAD, KIND_STORE, KIND_NOP, KIND_ECALL, KIND_EBREAK, KIND_ILLEGAL
  } instr_kind_e;

  localparam data_t ECALL_INSTR  = 32'h0000_0073;
  localparam data_t EBREAK_INSTR = 32'h0010_0073;
  localparam data_t WFI_INSTR    = 32'h1050_0073;

  //////////////////////////////
  // Control structs
  //////////////////////////////
  typedef struct packed {
    instr_kind_e kind;
    alu_op_e     alu_op;
    imm_fmt_e    imm_fmt;
    logic [2:0]  funct3;   // Width and sign for the LSU
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        use_rs1;
    logic        use_rs2;
    logic        use_imm;
    logic        use_pc;
  } decode_t;

  typedef struct packed {
    logic      wb_en;
    alu_op_e   alu_op;
    reg_addr_t rd;
    logic      use_pc;
    logic      is_imm;
  } alu_ctrl_t;

  typedef struct packed {
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
  } rf_req_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] ctrl;  // Store flag, then funct3
    reg_addr_t  rd;
  } lsu_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/instr_classifier.sv ====
// Pure combinational decode of RV32I base words, and branches, jumps and CSR ops decode as illegal
`timescale 1ns/1ps
`default_nettype none

module instr_classifier import rv_decoder_pkg::*; (
  input  data_t   instr_i,
  output decode_t dec_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_op;

  assign opcode   = opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign shift_op = (funct3 == 3'b001) || (funct3 == 3'b101);  // SLL, SRL and SRA

  always_comb begin
    dec_o         = '0;
    dec_o.kind    = KIND_ILLEGAL;  // Anything not matched below
    dec_o.alu_op  = ALU_OP_ADD;
    dec_o.imm_fmt = IMM_NONE;
    dec_o.funct3  = funct3;
    dec_o.rs1     = instr_i[19:15];
    dec_o.rs2     = instr_i[24:20];
    dec_o.rd      = instr_i[11:7];

    case (opcode)
      OPCODE_OP: begin
        // Bit 30 only selects SUB and SRA
        if (funct7 == 7'b0 || (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec_o.kind    = KIND_ALU;
          dec_o.alu_op  = alu_op_e'({instr_i[30], funct3});
          dec_o.use_rs1 = 1'b1;
          dec_o.use_rs2 = 1'b1;
        end
      end
      OPCODE_OPIMM: begin
        dec_o.kind    = KIND_ALU;
        dec_o.use_rs1 = 1'b1;
        dec_o.use_imm = 1'b1;
        if (shift_op) begin
          dec_o.imm_fmt = IMM_I_SHIFT;
          dec_o.alu_op  = alu_op_e'({instr_i[30], funct3});
          if (!(funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b101))) begin
            dec_o.kind    = KIND_ILLEGAL;
            dec_o.use_rs1 = 1'b0;  // No stall ahead of the illegal flag
          end
        end else begin
          dec_o.imm_fmt = IMM_I;
          dec_o.alu_op  = alu_op_e'({1'b0, funct3});
        end
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        dec_o.kind    = KIND_ALU;
        dec_o.imm_fmt = IMM_U;
        dec_o.use_imm = 1'b1;
        dec_o.use_pc  = (opcode == OPCODE_AUIPC);  // LUI adds to x0
      end
      OPCODE_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          dec_o.kind    = KIND_LOAD;
          dec_o.imm_fmt = IMM_I;
          dec_o.use_rs1 = 1'b1;
          dec_o.use_imm = 1'b1;
        end
      end
      OPCODE_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          dec_o.kind    = KIND_STORE;
          dec_o.imm_fmt = IMM_S;
          dec_o.use_rs1 = 1'b1;
          dec_o.use_rs2 = 1'b1;
          dec_o.use_imm = 1'b1;
        end
      end
      OPCODE_MISCMEM: begin
        if (funct3 == 3'b000) begin
          dec_o.kind = KIND_NOP;  // FENCE needs no action in order
        end
      end
      OPCODE_SYSTEM: begin
        if (instr_i == ECALL_INSTR) begin
          dec_o.kind = KIND_ECALL;
        end else if (instr_i == EBREAK_INSTR) begin
          dec_o.kind = KIND_EBREAK;
        end else if (instr_i == WFI_INSTR) begin
          dec_o.kind = KIND_NOP;
        end
      end
      default: ;
    endcase

    // Unused fields read as x0 so hazard and RF ports stay quiet
    if (!dec_o.use_rs1) begin
      dec_o.rs1 = '0;
    end
    if (!dec_o.use_rs2) begin
      dec_o.rs2 = '0;
    end
    if (!(dec_o.kind inside {KIND_ALU, KIND_LOAD})) begin
      dec_o.rd = '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
// Shift amounts are sign extended from 5 bits, so the ALU must use only the low 5 bits
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decoder_pkg::*; (
  input  data_t    instr_i,
  input  imm_fmt_e fmt_i,
  output data_t    imm_o
);

  //////////////////////////////
  // Format fields
  //////////////////////////////
  data_t imm_i;
  data_t imm_shift;
  data_t imm_s;
  data_t imm_u;

  assign imm_i     = {{(DATA_WIDTH-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_shift = {{(DATA_WIDTH-5){instr_i[24]}}, instr_i[24:20]};  // shamt field
  assign imm_s     = {{(DATA_WIDTH-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u     = {instr_i[31:12], 12'b0};  // Low bits cleared

  //////////////////////////////
  // Select
  //////////////////////////////
  always_comb begin
    case (fmt_i)
      IMM_I: begin
        imm_o = imm_i;
      end
      IMM_I_SHIFT: begin
        imm_o = imm_shift;
      end
      IMM_S: begin
        imm_o = imm_s;
      end
      IMM_U: begin
        imm_o = imm_u;
      end
      default: begin
        imm_o = '0;  // IMM_NONE
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/issue_seq.sv ====
// Fetch must hold instr_i until ready_o goes high, and ECALL, EBREAK or illegal halt until reset
`timescale 1ns/1ps
`default_nettype none

module issue_seq import rv_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  data_t     instr_addr_i,
  input  decode_t   dec_i,
  input  data_t     imm_i,
  input  logic      lsu_read_complete_i,
  output logic      ready_o,
  output data_t     instr_addr_o,
  output alu_ctrl_t alu_ctrl_o,
  output rf_req_t   rf_req_o,
  output data_t     imm_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output logic      illegal_o,
  output logic      ecall_o,
  output logic      ebreak_o
);

  typedef enum logic [3:0] {
    ST_OK, ST_STALL, ST_LOAD_ADDR, ST_LOAD_REQ, ST_LOAD_WAIT,
    ST_STORE_ADDR, ST_SYS_FLAG, ST_SYS_HALT, ST_ERROR
  } state_e;

  state_e    state_q, state_d;
  reg_addr_t prev_rd_q, prev_rd_d;  // rd issued at the last edge
  logic      hazard;
  logic      ready_d;
  alu_ctrl_t alu_d;
  rf_req_t   rf_d;
  data_t     imm_d;
  lsu_ctrl_t lsu_d;
  logic      illegal_d, ecall_d, ebreak_d;

  // prev_rd_q is zero after a stall, so the retry never stalls again
  assign hazard = (prev_rd_q != '0) &&
                  ((dec_i.use_rs1 && dec_i.rs1 == prev_rd_q) ||
                   (dec_i.use_rs2 && dec_i.rs2 == prev_rd_q));

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////
  always_comb begin
    state_d   = state_q;
    prev_rd_d = '0;
    ready_d   = 1'b1;
    alu_d     = '0;
    rf_d      = '0;
    imm_d     = '0;
    lsu_d     = '0;
    illegal_d = 1'b0;
    ecall_d   = 1'b0;
    ebreak_d  = 1'b0;

    case (state_q)
      ST_OK, ST_STALL: begin
        state_d = ST_OK;
        if (instr_valid_i && hazard) begin
          state_d = ST_STALL;
          ready_d = 1'b0;
        end else if (instr_valid_i) begin
          case (dec_i.kind)
            KIND_ALU: begin
              alu_d     = '{wb_en: 1'b1, alu_op: dec_i.alu_op, rd: dec_i.rd,
                            use_pc: dec_i.use_pc, is_imm: dec_i.use_imm};
              rf_d      = '{rs1_addr: dec_i.rs1, rs2_addr: dec_i.rs2};
              imm_d     = imm_i;
              prev_rd_d = dec_i.rd;
            end
            KIND_LOAD, KIND_STORE: begin
              // Address phase through the ALU
              alu_d.alu_op = ALU_OP_ADD;
              alu_d.is_imm = 1'b1;
              rf_d         = '{rs1_addr: dec_i.rs1, rs2_addr: dec_i.rs2};
              imm_d        = imm_i;
              ready_d      = 1'b0;
              state_d      = (dec_i.kind == KIND_LOAD) ? ST_LOAD_ADDR : ST_STORE_ADDR;
            end
            KIND_ECALL, KIND_EBREAK: begin
              ready_d = 1'b0;
              state_d = ST_SYS_FLAG;
            end
            KIND_ILLEGAL: begin
              illegal_d = 1'b1;
              ready_d   = 1'b0;
              state_d   = ST_ERROR;
            end
            default: ;  // FENCE and WFI
          endcase
        end
      end
      ST_LOAD_ADDR: begin
        lsu_d   = '{valid: 1'b1, ctrl: {1'b0, dec_i.funct3}, rd: dec_i.rd};
        ready_d = 1'b0;
        state_d = ST_LOAD_REQ;
      end
      ST_LOAD_REQ, ST_LOAD_WAIT: begin
        ready_d = lsu_read_complete_i;
        if (lsu_read_complete_i) begin
          prev_rd_d = dec_i.rd;  // Load data lands in rd now
          state_d   = ST_OK;
        end else begin
          state_d = ST_LOAD_WAIT;
        end
      end
      ST_STORE_ADDR: begin
        lsu_d   = '{valid: 1'b1, ctrl: {1'b1, dec_i.funct3}, rd: '0};
        rf_d    = '{rs1_addr: dec_i.rs1, rs2_addr: dec_i.rs2};  // rs2 carries store data
        state_d = ST_OK;
      end
      ST_SYS_FLAG: begin
        ecall_d  = (dec_i.kind == KIND_ECALL);
        ebreak_d = (dec_i.kind == KIND_EBREAK);
        ready_d  = 1'b0;
        state_d  = ST_SYS_HALT;
      end
      ST_SYS_HALT: begin
        ready_d = 1'b0;  // Trap handler redirects fetch
      end
      default: begin
        illegal_d = 1'b1;  // ST_ERROR
        ready_d   = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q    <= ST_OK;
      prev_rd_q  <= '0;
      ready_o    <= 1'b1;
      alu_ctrl_o <= '0;
      lsu_ctrl_o <= '0;
      illegal_o  <= 1'b0;
      ecall_o    <= 1'b0;
      ebreak_o   <= 1'b0;
    end else begin
      state_q    <= state_d;
      prev_rd_q  <= prev_rd_d;
      ready_o    <= ready_d;
      alu_ctrl_o <= alu_d;
      lsu_ctrl_o <= lsu_d;
      illegal_o  <= illegal_d;
      ecall_o    <= ecall_d;
      ebreak_o   <= ebreak_d;
    end
  end

  always_ff @(posedge clk_i) begin
    instr_addr_o <= instr_addr_i;
    imm_o        <= imm_d;
    rf_req_o     <= rf_d;
  end

  // One request per load or store toward the LSU
  a_lsu_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
    lsu_ctrl_o.valid |=> !lsu_ctrl_o.valid);
  a_illegal_blocks: assert property (@(posedge clk_i) disable iff (!rstn_i)
    illegal_o |-> !ready_o);
  a_trap_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(ecall_o && ebreak_o));

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
// RV32I decode stage without branches, jumps or CSRs, and all outputs are registered
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  data_t     instr_i,
  input  data_t     instr_addr_i,
  input  logic      instr_valid_i,
  input  logic      lsu_read_complete_i,
  output logic      ready_o,
  output data_t     instr_addr_o,
  output alu_ctrl_t alu_ctrl_o,
  output rf_req_t   rf_req_o,
  output data_t     imm_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output logic      illegal_o,
  output logic      ecall_o,
  output logic      ebreak_o
);

  decode_t dec;
  data_t   imm;

  instr_classifier u_instr_classifier (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  imm_gen u_imm_gen (
    .instr_i (instr_i),
    .fmt_i   (dec.imm_fmt),
    .imm_o   (imm)
  );

  issue_seq u_issue_seq (
    .clk_i               (clk_i),
    .rstn_i              (rstn_i),
    .instr_valid_i       (instr_valid_i),
    .instr_addr_i        (instr_addr_i),
    .dec_i               (dec),
    .imm_i               (imm),
    .lsu_read_complete_i (lsu_read_complete_i),
    .ready_o             (ready_o),
    .instr_addr_o        (instr_addr_o),
    .alu_ctrl_o          (alu_ctrl_o),
    .rf_req_o            (rf_req_o),
    .imm_o               (imm_o),
    .lsu_ctrl_o          (lsu_ctrl_o),
    .illegal_o           (illegal_o),
    .ecall_o             (ecall_o),
    .ebreak_o            (ebreak_o)
  );

endmodule

`default_nettype wire

// ==== include/tb_rv_encode.svh ====
// Builds RV32I words from fields and leaves field ranges and funct codes to the caller
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

//////////////////////////////
// Instruction formats
//////////////////////////////
function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [4:0] rd, input logic [6:0] opcode);
  return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

// Also used for shifts, with funct7 and shamt packed into imm
function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] funct3, input logic [4:0] rd,
                                       input logic [6:0] opcode);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] funct3,
                                       input logic [6:0] opcode);
  return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};  // Split immediate
endfunction

function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

`endif

// ==== sim/tb_rv_decoder.sv ====
// Directed tests with one instruction in flight while fetch holds each word until ready_o is high
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder import rv_decoder_pkg::*; ();

  localparam int MAX_CYCLES = 400;

  logic      clk_i;
  logic      rstn_i;
  data_t     instr_i;
  data_t     instr_addr_i;
  logic      instr_valid_i;
  logic      lsu_read_complete_i;
  logic      ready_o;
  data_t     instr_addr_o;
  alu_ctrl_t alu_ctrl_o;
  rf_req_t   rf_req_o;
  data_t     imm_o;
  lsu_ctrl_t lsu_ctrl_o;
  logic      illegal_o;
  logic      ecall_o;
  logic      ebreak_o;

  int        cycle_cnt  = 0;
  int        err_cnt    = 0;
  int        tests_pass = 0;
  int        tests_fail = 0;
  data_t     sent_addr;
  reg_addr_t last_rd;     // rd of the last issued ALU op

  `include "tb_rv_encode.svh"

  rv_decoder u_rv_decoder (
    .clk_i               (clk_i),
    .rstn_i              (rstn_i),
    .instr_i             (instr_i),
    .instr_addr_i        (instr_addr_i),
    .instr_valid_i       (instr_valid_i),
    .lsu_read_complete_i (lsu_read_complete_i),
    .ready_o             (ready_o),
    .instr_addr_o        (instr_addr_o),
    .alu_ctrl_o          (alu_ctrl_o),
    .rf_req_o            (rf_req_o),
    .imm_o               (imm_o),
    .lsu_ctrl_o          (lsu_ctrl_o),
    .illegal_o           (illegal_o),
    .ecall_o             (ecall_o),
    .ebreak_o            (ebreak_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a test never finished", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus and reporting
  //////////////////////////////
  task automatic next_cycle();
    @(negedge clk_i);  // Outputs settled and inputs may change
  endtask

  task automatic apply_reset();
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    repeat (16) next_cycle();
    rstn_i = 1'b1;
  endtask

  task automatic present(input data_t word);
    instr_i       = word;
    instr_addr_i  = data_t'($urandom) & 32'hFFFF_FFFC;
    instr_valid_i = 1'b1;
    sent_addr     = instr_addr_i;
  endtask

  task automatic go_idle();
    instr_valid_i = 1'b0;
  endtask

  task automatic word_mismatch(input string name, input string what, input data_t exp,
                               input data_t act);
    $display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
    err_cnt++;
  endtask

  task automatic flag_mismatch(input string name, input string what, input logic exp,
                               input logic act);
    $display("FAIL %s %s: expected %b, actual %b", name, what, exp, act);
    err_cnt++;
  endtask

  task automatic test_done(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  function automatic reg_addr_t other_reg(input reg_addr_t avoid);
    reg_addr_t r;
    r = 5'($urandom);
    if (avoid != '0 && r == avoid) r = r + 5'd1;
    return r;
  endfunction

  task automatic check_idle(input string name);
    if (ready_o !== 1'b1) flag_mismatch(name, "ready_o", 1'b1, ready_o);
    if (alu_ctrl_o.wb_en !== 1'b0) flag_mismatch(name, "wb_en", 1'b0, alu_ctrl_o.wb_en);
    if (lsu_ctrl_o.valid !== 1'b0) flag_mismatch(name, "lsu valid", 1'b0, lsu_ctrl_o.valid);
    if (illegal_o !== 1'b0) flag_mismatch(name, "illegal_o", 1'b0, illegal_o);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic alu_decode();
    int          start;
    reg_addr_t   rd, rs1, rs2;
    logic [2:0]  f3;
    logic        b30;
    logic [11:0] imm12;
    logic [19:0] imm20;
    data_t       w, exp_imm;
    alu_ctrl_t   exp_alu;
    start = err_cnt;
    go_idle();
    next_cycle();
    last_rd = '0;
    for (int i = 0; i < 8; i++) begin
      rd      = 5'($urandom);
      rs1     = other_reg(last_rd);
      rs2     = other_reg(last_rd);
      f3      = 3'($urandom);
      b30     = 1'($urandom);
      imm12   = 12'($urandom);
      imm20   = 20'($urandom);
      exp_alu = '0;
      exp_alu.wb_en = 1'b1;
      exp_alu.rd    = rd;
      exp_imm = '0;
      case (i % 4)
        0: begin  // OP with bit 30 only for SUB and SRA
          if (f3 != 3'b000 && f3 != 3'b101) b30 = 1'b0;
          w = r_word({1'b0, b30, 5'b0}, rs2, rs1, f3, rd, OPCODE_OP);
          exp_alu.alu_op = alu_op_e'({b30, f3});
        end
        1: begin
          if (i == 1) begin
            f3  = 3'b101;  // SRAI
            b30 = 1'b1;
          end
          exp_alu.is_imm = 1'b1;
          if (f3 == 3'b001 || f3 == 3'b101) begin
            if (f3 == 3'b001) b30 = 1'b0;
            w = i_word({1'b0, b30, 5'b0, imm12[4:0]}, rs1, f3, rd, OPCODE_OPIMM);
            exp_alu.alu_op = alu_op_e'({b30, f3});
            exp_imm = {{27{imm12[4]}}, imm12[4:0]};
          end else begin
            w = i_word(imm12, rs1, f3, rd, OPCODE_OPIMM);
            exp_alu.alu_op = alu_op_e'({1'b0, f3});
            exp_imm = {{20{imm12[11]}}, imm12};
          end
        end
        default: begin  // LUI, then AUIPC
          exp_alu.is_imm = 1'b1;
          exp_alu.use_pc = (i % 4 == 3);
          w = u_word(imm20, rd, (i % 4 == 3) ? OPCODE_AUIPC : OPCODE_LUI);
          exp_imm = {imm20, 12'b0};
        end
      endcase
      present(w);
      next_cycle();
      if (alu_ctrl_o !== exp_alu)
        word_mismatch("alu_decode", "alu_ctrl_o", 32'(exp_alu), 32'(alu_ctrl_o));
      if (ready_o !== 1'b1) flag_mismatch("alu_decode", "ready_o", 1'b1, ready_o);
      if (i % 4 < 2 && rf_req_o.rs1_addr !== rs1)
        word_mismatch("alu_decode", "rs1_addr", 32'(rs1), 32'(rf_req_o.rs1_addr));
      if (i % 4 == 0 && rf_req_o.rs2_addr !== rs2)
        word_mismatch("alu_decode", "rs2_addr", 32'(rs2), 32'(rf_req_o.rs2_addr));
      if (imm_o !== exp_imm) word_mismatch("alu_decode", "imm_o", exp_imm, imm_o);
      if (instr_addr_o !== sent_addr)
        word_mismatch("alu_decode", "instr_addr_o", sent_addr, instr_addr_o);
      last_rd = rd;
    end
    go_idle();
    test_done("alu_decode", start);
  endtask

  task automatic hazard_stall();
    int start;
    start = err_cnt;
    go_idle();
    next_cycle();
    present(r_word(7'b0, 5'd2, 5'd1, 3'b000, 5'd5, OPCODE_OP));  // ADD x5
    next_cycle();
    if (alu_ctrl_o.wb_en !== 1'b1) flag_mismatch("hazard_stall", "wb_en", 1'b1, alu_ctrl_o.wb_en);
    present(r_word(7'b0100000, 5'd3, 5'd5, 3'b000, 5'd6, OPCODE_OP));  // SUB reads x5
    next_cycle();
    if (alu_ctrl_o.wb_en !== 1'b0) flag_mismatch("hazard_stall", "wb_en", 1'b0, alu_ctrl_o.wb_en);
    if (ready_o !== 1'b0) flag_mismatch("hazard_stall", "ready_o", 1'b0, ready_o);
    next_cycle();  // Word held through the stall
    if (alu_ctrl_o.wb_en !== 1'b1) flag_mismatch("hazard_stall", "wb_en", 1'b1, alu_ctrl_o.wb_en);
    if (alu_ctrl_o.alu_op !== ALU_OP_SUB)
      word_mismatch("hazard_stall", "alu_op", 32'(ALU_OP_SUB), 32'(alu_ctrl_o.alu_op));
    if (ready_o !== 1'b1) flag_mismatch("hazard_stall", "ready_o", 1'b1, ready_o);
    present(r_word(7'b0, 5'd2, 5'd1, 3'b000, 5'd0, OPCODE_OP));  // Writes x0
    next_cycle();
    present(i_word(12'd3, 5'd0, 3'b000, 5'd8, OPCODE_OPIMM));  // Reads x0
    next_cycle();
    if (alu_ctrl_o.wb_en !== 1'b1) flag_mismatch("hazard_stall", "x0 wb_en", 1'b1, alu_ctrl_o.wb_en);
    if (ready_o !== 1'b1) flag_mismatch("hazard_stall", "x0 ready_o", 1'b1, ready_o);
    go_idle();
    test_done("hazard_stall", start);
  endtask

  task automatic store_sequence();
    int          start;
    reg_addr_t   rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    start = err_cnt;
    rs1   = 5'($urandom);
    rs2   = 5'($urandom);
    f3    = 3'($urandom_range(2, 0));
    imm12 = 12'($urandom);
    go_idle();
    next_cycle();
    present(s_word(imm12, rs2, rs1, f3, OPCODE_STORE));
    next_cycle();  // Address phase
    if (alu_ctrl_o.is_imm !== 1'b1) flag_mismatch("store", "is_imm", 1'b1, alu_ctrl_o.is_imm);
    if (imm_o !== {{20{imm12[11]}}, imm12})
      word_mismatch("store", "imm_o", {{20{imm12[11]}}, imm12}, imm_o);
    if (ready_o !== 1'b0) flag_mismatch("store", "ready_o", 1'b0, ready_o);
    if (lsu_ctrl_o.valid !== 1'b0) flag_mismatch("store", "early valid", 1'b0, lsu_ctrl_o.valid);
    next_cycle();
    if (lsu_ctrl_o.valid !== 1'b1) flag_mismatch("store", "lsu valid", 1'b1, lsu_ctrl_o.valid);
    if (lsu_ctrl_o.ctrl !== {1'b1, f3})
      word_mismatch("store", "lsu ctrl", 32'({1'b1, f3}), 32'(lsu_ctrl_o.ctrl));
    if (ready_o !== 1'b1) flag_mismatch("store", "ready_o", 1'b1, ready_o);
    go_idle();
    next_cycle();
    if (lsu_ctrl_o.valid !== 1'b0) flag_mismatch("store", "second valid", 1'b0, lsu_ctrl_o.valid);
    test_done("store_sequence", start);
  endtask

  task automatic load_backpressure();
    int          start;
    int          delay;
    int          waits;
    reg_addr_t   rd, rs1;
    logic [2:0]  f3;
    logic [11:0] imm12;
    start = err_cnt;
    rd    = 5'($urandom_range(31, 1));
    rs1   = 5'($urandom);
    f3    = 3'($urandom_range(5, 0));
    if (f3 == 3'b011) f3 = 3'b100;  // No LD in RV32I
    imm12 = 12'($urandom);
    delay = $urandom_range(6, 1);
    go_idle();
    next_cycle();
    present(i_word(imm12, rs1, f3, rd, OPCODE_LOAD));
    next_cycle();
    if (alu_ctrl_o.is_imm !== 1'b1) flag_mismatch("load", "is_imm", 1'b1, alu_ctrl_o.is_imm);
    if (imm_o !== {{20{imm12[11]}}, imm12})
      word_mismatch("load", "imm_o", {{20{imm12[11]}}, imm12}, imm_o);
    if (ready_o !== 1'b0) flag_mismatch("load", "ready_o", 1'b0, ready_o);
    next_cycle();  // Request toward the LSU
    if (lsu_ctrl_o.valid !== 1'b1) flag_mismatch("load", "lsu valid", 1'b1, lsu_ctrl_o.valid);
    if (lsu_ctrl_o.ctrl !== {1'b0, f3})
      word_mismatch("load", "lsu ctrl", 32'({1'b0, f3}), 32'(lsu_ctrl_o.ctrl));
    if (lsu_ctrl_o.rd !== rd) word_mismatch("load", "lsu rd", 32'(rd), 32'(lsu_ctrl_o.rd));
    if (ready_o !== 1'b0) flag_mismatch("load", "ready_o", 1'b0, ready_o);
    repeat (delay) begin
      next_cycle();
      if (ready_o !== 1'b0) flag_mismatch("load", "waiting ready_o", 1'b0, ready_o);
      if (lsu_ctrl_o.valid !== 1'b0) flag_mismatch("load", "repeat valid", 1'b0, lsu_ctrl_o.valid);
    end
    lsu_read_complete_i = 1'b1;
    waits = 0;
    do begin
      next_cycle();
      waits++;
    end while (ready_o !== 1'b1);
    lsu_read_complete_i = 1'b0;
    if (waits != 1) word_mismatch("load", "edges to ready", 32'd1, waits);
    go_idle();
    test_done("load_backpressure", start);
  endtask

  task automatic trap_pulse(input string name, input data_t word, input logic want_ecall);
    int n_ecall;
    int n_ebreak;
    n_ecall  = 0;
    n_ebreak = 0;
    apply_reset();
    present(word);
    repeat (5) begin
      next_cycle();
      if (ecall_o === 1'b1) n_ecall++;
      if (ebreak_o === 1'b1) n_ebreak++;
      if (ready_o !== 1'b0) flag_mismatch(name, "ready_o", 1'b0, ready_o);
    end
    if (n_ecall != int'(want_ecall)) word_mismatch(name, "ecall pulses", 32'(want_ecall), n_ecall);
    if (n_ebreak != int'(!want_ecall))
      word_mismatch(name, "ebreak pulses", 32'(!want_ecall), n_ebreak);
  endtask

  task automatic system_illegal();
    int start;
    start = err_cnt;
    trap_pulse("ecall", ECALL_INSTR, 1'b1);
    trap_pulse("ebreak", EBREAK_INSTR, 1'b0);
    apply_reset();
    present(32'h0000_007F);  // Undefined major opcode
    repeat (4) begin
      next_cycle();
      if (illegal_o !== 1'b1) flag_mismatch("illegal", "illegal_o", 1'b1, illegal_o);
      if (ready_o !== 1'b0) flag_mismatch("illegal", "ready_o", 1'b0, ready_o);
    end
    apply_reset();
    present(WFI_INSTR);
    next_cycle();
    check_idle("wfi");
    go_idle();
    next_cycle();
    check_idle("valid_low");
    test_done("system_illegal", start);
  endtask

  initial begin
    void'($urandom(84995));
    rstn_i              = 1'b0;
    instr_i             = '0;
    instr_addr_i        = '0;
    instr_valid_i       = 1'b0;
    lsu_read_complete_i = 1'b0;
    sent_addr           = '0;
    last_rd             = '0;
    apply_reset();
    alu_decode();
    hazard_stall();
    store_sequence();
    load_backpressure();
    system_illegal();
    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_pass, tests_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_decoder.f ====
+incdir+include
hw/rv_decoder_pkg.sv
hw/instr_classifier.sv
hw/imm_gen.sv
hw/issue_seq.sv
hw/rv_decoder.sv
sim/tb_rv_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_decoder \
  -f rv_decoder.f -o tb_rv_decoder \
  && ./obj_dir/tb_rv_decoder | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }
grep -q "^All checks passed$" sim.log \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }
